// ==== Bender.yml ====
package:
  name: nru_mem

sources:
  - nru_pkg.sv
  - nru_bank.sv
  - nru_read_lane.sv
  - nru_update_ctrl.sv
  - nru_sva_check.sv
  - nru_mem_top.sv
  - target: test
    files:
      - nru_tb_clk.sv
      - nru_tb.sv

// ==== nru_bank.sv ====
`timescale 1ns/100ps

module nru_bank (
  input  logic                         clk,
  input  logic                         rd,
  input  logic [nru_pkg::BITADDR-1:0]  rd_addr,
  input  nru_pkg::nru_bank_wr_t        wr,
  output logic [nru_pkg::WIDTH-1:0]    rd_data
);

  // contents come up as zero, reset leaves them alone.
  logic [nru_pkg::WIDTH-1:0] mem [nru_pkg::NUMADDR] = '{default: '0};
  logic [nru_pkg::WIDTH-1:0] rd_q;

  // the write lands at the edge ending its cycle.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // first read stage samples the array before a write at the same edge,
  // so a read in the write cycle sees the old word.
  always_ff @(posedge clk) begin
    if (rd) begin
      rd_q <= mem[rd_addr];
    end
    rd_data <= rd_q;
  end

  // a read address must be a known word of the array.
  assert_rd_range: assert property (
    @(posedge clk) rd |-> (!$isunknown(rd_addr) && (rd_addr < nru_pkg::NUMADDR))
  );

endmodule

// ==== nru_mem_top.sv ====
`timescale 1ns/100ps

module nru_mem_top (
  input  logic              clk,
  input  logic              rst,
  input  nru_pkg::nru_req_t req [nru_pkg::NUMRUPT],
  output nru_pkg::nru_rsp_t rsp [nru_pkg::NUMRUPT]
);

  // raw words returned by each lane.
  nru_pkg::nru_partner_t partner [nru_pkg::NUMRUPT];

  // one write stream per logical bank, shared by both lanes.
  nru_pkg::nru_bank_wr_t bank_wr [nru_pkg::NUMRUPT];

  nru_read_lane lane_0_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req[0]),
    .bank_wr (bank_wr),
    .rsp     (rsp[0]),
    .partner (partner[0])
  );

  nru_read_lane lane_1_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req[1]),
    .bank_wr (bank_wr),
    .rsp     (rsp[1]),
    .partner (partner[1])
  );

  // turns the port writes into bank writes using the held partner words.
  nru_update_ctrl update_ctrl_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .partner (partner),
    .bank_wr (bank_wr)
  );

  nru_sva_check sva_check_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .bank_wr (bank_wr)
  );

endmodule

// ==== nru_pkg.sv ====
package nru_pkg;

  // word geometry of the logical memory.
  localparam int WIDTH   = 16;
  localparam int NUMADDR = 256;
  localparam int BITADDR = 8;

  // one port per logical bank, so both counts are the same.
  localparam int NUMRUPT = 2;

  // bank read latency and the gap from read data to the port write.
  localparam int SRAM_DELAY = 2;
  localparam int UPD_DELAY  = 2;

  // a port write lands this many cycles after the read that opened it.
  localparam int UPD_LAT = SRAM_DELAY + UPD_DELAY;

  // request of one port. read and write are independent and may both be high.
  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   din;
  } nru_req_t;

  // response of one port, valid two cycles after the read.
  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] dout;
  } nru_rsp_t;

  // a write into one logical bank. It goes to both physical copies of it.
  typedef struct packed {
    logic               en;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
  } nru_bank_wr_t;

  // raw words a lane got back from its copies of logical banks 0 and 1.
  typedef struct packed {
    logic               vld;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   word0;
    logic [WIDTH-1:0]   word1;
  } nru_partner_t;

endpackage

// ==== nru_read_lane.sv ====
`timescale 1ns/100ps

module nru_read_lane (
  input  logic                  clk,
  input  logic                  rst,
  input  nru_pkg::nru_req_t     req,
  input  nru_pkg::nru_bank_wr_t bank_wr [nru_pkg::NUMRUPT],
  output nru_pkg::nru_rsp_t     rsp,
  output nru_pkg::nru_partner_t partner
);

  logic [nru_pkg::SRAM_DELAY-1:0] vld_q;
  logic [nru_pkg::BITADDR-1:0]    addr_q [nru_pkg::SRAM_DELAY];
  logic [nru_pkg::WIDTH-1:0]      word   [nru_pkg::NUMRUPT];

  // this lane's private copy of each logical bank. Every copy takes the
  // same writes, so all readers agree on the contents.
  genvar b;
  for (b = 0; b < nru_pkg::NUMRUPT; b++) begin : copy_loop
    nru_bank bank_inst (
      .clk     (clk),
      .rd      (req.read),
      .rd_addr (req.addr),
      .wr      (bank_wr[b]),
      .rd_data (word[b])
    );
  end

  // valid runs alongside the bank pipeline so two reads can be in flight.
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[nru_pkg::SRAM_DELAY-2:0], req.read};
    end
  end

  always_ff @(posedge clk) begin
    addr_q[0] <= req.addr;
    for (int k = 1; k < nru_pkg::SRAM_DELAY; k++) begin
      addr_q[k] <= addr_q[k-1];
    end
  end

  // the logical word is the XOR of both logical banks.
  assign rsp.vld  = vld_q[nru_pkg::SRAM_DELAY-1];
  assign rsp.dout = word[0] ^ word[1];

  // the raw words go on to the update controller, which needs the
  // partner bank's old value for a following write.
  assign partner.vld   = vld_q[nru_pkg::SRAM_DELAY-1];
  assign partner.addr  = addr_q[nru_pkg::SRAM_DELAY-1];
  assign partner.word0 = word[0];
  assign partner.word1 = word[1];

endmodule

// ==== nru_sva_check.sv ====
`timescale 1ns/100ps

module nru_sva_check (
  input logic                  clk,
  input logic                  rst,
  input nru_pkg::nru_req_t     req     [nru_pkg::NUMRUPT],
  input nru_pkg::nru_rsp_t     rsp     [nru_pkg::NUMRUPT],
  input nru_pkg::nru_bank_wr_t bank_wr [nru_pkg::NUMRUPT]
);

  // logical contents as the ports should see them.
  logic [nru_pkg::WIDTH-1:0] shadow [nru_pkg::NUMADDR] = '{default: '0};

  logic [nru_pkg::UPD_LAT-1:0] pipe_vld  [nru_pkg::NUMRUPT];
  logic [nru_pkg::BITADDR-1:0] pipe_addr [nru_pkg::NUMRUPT][nru_pkg::UPD_LAT];
  logic [nru_pkg::WIDTH-1:0]   pipe_exp  [nru_pkg::NUMRUPT][nru_pkg::SRAM_DELAY];

  // a write is legal only with a read UPD_LAT cycles before it,
  // and it takes that read's address.
  always_ff @(posedge clk) begin
    for (int p = 0; p < nru_pkg::NUMRUPT; p++) begin
      if (req[p].write && pipe_vld[p][nru_pkg::UPD_LAT-1]) begin
        shadow[pipe_addr[p][nru_pkg::UPD_LAT-1]] <= req[p].din;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < nru_pkg::NUMRUPT; p++) begin
      if (rst) begin
        pipe_vld[p] <= '0;
      end else begin
        pipe_vld[p] <= {pipe_vld[p][nru_pkg::UPD_LAT-2:0], req[p].read};
      end
    end
  end

  // expected data is taken in the read cycle itself, before any write
  // landing at the same edge.
  always_ff @(posedge clk) begin
    for (int p = 0; p < nru_pkg::NUMRUPT; p++) begin
      pipe_addr[p][0] <= req[p].addr;
      pipe_exp[p][0]  <= shadow[req[p].addr];
      for (int k = 1; k < nru_pkg::UPD_LAT; k++) begin
        pipe_addr[p][k] <= pipe_addr[p][k-1];
      end
      for (int k = 1; k < nru_pkg::SRAM_DELAY; k++) begin
        pipe_exp[p][k] <= pipe_exp[p][k-1];
      end
    end
  end

  genvar p;
  for (p = 0; p < nru_pkg::NUMRUPT; p++) begin : port_loop
    // vld follows read by exactly SRAM_DELAY, never early and never extra.
    assert_rsp_vld: assert property (
      @(posedge clk) disable iff (rst)
      1'b1 |-> ##(nru_pkg::SRAM_DELAY)
        (rsp[p].vld == $past(req[p].read, nru_pkg::SRAM_DELAY))
    );

    assert_rsp_dout: assert property (
      @(posedge clk) disable iff (rst)
      pipe_vld[p][nru_pkg::SRAM_DELAY-1] |->
        (rsp[p].dout == pipe_exp[p][nru_pkg::SRAM_DELAY-1])
    );

    // Bank writes must follow the read that opened the update.
    assert_wr_addr: assert property (
      @(posedge clk) disable iff (rst)
      bank_wr[p].en |->
        (pipe_vld[p][nru_pkg::UPD_LAT-1] &&
         (bank_wr[p].addr == pipe_addr[p][nru_pkg::UPD_LAT-1]))
    );
  end

endmodule

// ==== nru_tb.sv ====
`timescale 1ns/100ps

module nru_tb;

  typedef struct packed {
    logic                        port;
    logic [nru_pkg::BITADDR-1:0] addr;
    logic                        upd;
    logic [nru_pkg::WIDTH-1:0]   data;
    logic [3:0]                  gap;
  } stim_t;

  typedef struct packed {
    logic [nru_pkg::WIDTH-1:0] data;
    logic [31:0]               cycle;
    logic [7:0]                idx;
  } exp_t;

  typedef struct packed {
    logic                        port;
    logic [nru_pkg::BITADDR-1:0] addr;
    logic [nru_pkg::WIDTH-1:0]   data;
    logic [31:0]                 due;
  } wr_t;

  logic              clk;
  logic              rst;
  nru_pkg::nru_req_t req [nru_pkg::NUMRUPT];
  nru_pkg::nru_rsp_t rsp [nru_pkg::NUMRUPT];

  stim_t                       tbl [$];
  string                       names [$];
  exp_t                        exp_q [nru_pkg::NUMRUPT][$];
  wr_t                         wq [$];
  logic [nru_pkg::WIDTH-1:0]   model [nru_pkg::NUMADDR];
  logic                        commit_vld  [nru_pkg::NUMRUPT];
  logic [nru_pkg::BITADDR-1:0] commit_addr [nru_pkg::NUMRUPT];
  logic [nru_pkg::WIDTH-1:0]   commit_data [nru_pkg::NUMRUPT];
  logic [31:0]                 cycle_cnt = '0;
  logic                        stim_done = 1'b0;
  integer                      seed = 32'h082091d6;
  int                          errors = 0;
  int                          waited;

  nru_tb_clk clk_inst (
    .clk (clk),
    .rst (rst)
  );

  nru_mem_top nru_mem_top_inst (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic add_entry(input string name, input logic port, input logic [7:0] addr,
                           input logic upd, input logic [15:0] data, input logic [3:0] gap);
    stim_t s;
    s.port = port;
    s.addr = addr;
    s.upd  = upd;
    s.data = data;
    s.gap  = gap;
    tbl.push_back(s);
    names.push_back(name);
  endtask

  // two updates of one address must keep their windows apart.
  function automatic logic addr_clashes(input int idx, input logic [7:0] addr);
    logic hit;
    int   j;
    hit = 1'b0;
    for (j = idx - 5; j < idx; j++) begin
      if (j >= 0 && tbl[j].upd && tbl[j].addr == addr) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic add_random(input int count);
    int          r;
    int          k;
    int          tries;
    logic        upd;
    logic [7:0]  addr;
    for (k = 0; k < count; k++) begin
      r     = $random(seed);
      upd   = r[1];
      addr  = r[11:4];
      tries = 0;
      while (upd && addr_clashes(tbl.size(), addr) && tries < 20) begin
        r     = $random(seed);
        addr  = r[7:0];
        tries = tries + 1;
      end
      if (addr_clashes(tbl.size(), addr)) begin
        upd = 1'b0;
      end
      add_entry($sformatf("rand_%0d", k), r[0], addr, upd, r[31:16], r[2] ? 4'd2 : 4'd1);
    end
  endtask

  task automatic build_table();
    add_entry("rd_unwritten", 1'b0, 8'h10, 1'b0, 16'h0000, 4'd1);
    add_entry("p0_upd_a",     1'b0, 8'h20, 1'b1, 16'ha5a5, 4'd1);
    add_entry("p1_rd_a",      1'b1, 8'h20, 1'b0, 16'h0000, 4'd5);
    add_entry("p1_upd_a",     1'b1, 8'h20, 1'b1, 16'h3c3c, 4'd5);
    add_entry("p0_rd_a2",     1'b0, 8'h20, 1'b0, 16'h0000, 4'd5);
    // both ports update in the same cycle, one logical bank each.
    add_entry("p0_upd_b",     1'b0, 8'h31, 1'b1, 16'h1234, 4'd5);
    add_entry("p1_upd_c",     1'b1, 8'h42, 1'b1, 16'hbeef, 4'd0);
    add_entry("p0_rd_c",      1'b0, 8'h42, 1'b0, 16'h0000, 4'd5);
    add_entry("p1_rd_b",      1'b1, 8'h31, 1'b0, 16'h0000, 4'd0);
    add_entry("p0_rd_b",      1'b0, 8'h31, 1'b0, 16'h0000, 4'd1);
    add_entry("p1_rd_c",      1'b1, 8'h42, 1'b0, 16'h0000, 4'd0);
    add_entry("b2b_p0_0",     1'b0, 8'h20, 1'b0, 16'h0000, 4'd1);
    add_entry("b2b_p1_0",     1'b1, 8'h31, 1'b0, 16'h0000, 4'd0);
    add_entry("b2b_p0_1",     1'b0, 8'h42, 1'b0, 16'h0000, 4'd1);
    add_entry("b2b_p1_1",     1'b1, 8'h10, 1'b0, 16'h0000, 4'd0);
    add_entry("b2b_p0_2",     1'b0, 8'h31, 1'b0, 16'h0000, 4'd1);
    add_entry("b2b_p1_2",     1'b1, 8'h20, 1'b0, 16'h0000, 4'd0);
    add_random(40);
  endtask

  // a write lands at the edge after its cycle, so the model takes it
  // only when the next cycle starts.
  task automatic advance(input int n);
    int c;
    int p;
    for (c = 0; c < n; c++) begin
      for (p = 0; p < nru_pkg::NUMRUPT; p++) begin
        if (commit_vld[p]) begin
          model[commit_addr[p]] = commit_data[p];
        end
        commit_vld[p] = 1'b0;
      end
      @(posedge clk);
      #1;
      req[0] = '0;
      req[1] = '0;
      while (wq.size() > 0 && wq[0].due == cycle_cnt) begin
        req[wq[0].port].write      = 1'b1;
        req[wq[0].port].din        = wq[0].data;
        commit_vld[wq[0].port]     = 1'b1;
        commit_addr[wq[0].port]    = wq[0].addr;
        commit_data[wq[0].port]    = wq[0].data;
        void'(wq.pop_front());
      end
    end
  endtask

  task automatic issue_read(input int i);
    stim_t s;
    exp_t  e;
    wr_t   w;
    s = tbl[i];
    req[s.port].read = 1'b1;
    req[s.port].addr = s.addr;
    e.data  = model[s.addr];
    e.cycle = cycle_cnt;
    e.idx   = i[7:0];
    exp_q[s.port].push_back(e);
    if (s.upd) begin
      w.port = s.port;
      w.addr = s.addr;
      w.data = s.data;
      w.due  = cycle_cnt + nru_pkg::UPD_LAT;
      wq.push_back(w);
    end
  endtask

  task automatic run_table();
    int i;
    for (i = 0; i < tbl.size(); i++) begin
      advance(tbl[i].gap);
      issue_read(i);
    end
    advance(nru_pkg::UPD_LAT + 4);
    stim_done = 1'b1;
  endtask

  task automatic watch_port(input int p);
    exp_t e;
    int   idle;
    int   wait_cnt;
    logic quit;
    idle = 0;
    quit = 1'b0;
    while (!quit && !(stim_done && exp_q[p].size() == 0)) begin
      if (exp_q[p].size() == 0) begin
        @(negedge clk);
        idle = idle + 1;
        if (rsp[p].vld !== 1'b0) begin
          $display("port %0d gave a response with no read outstanding", p);
          errors = errors + 1;
        end
        if (idle > 200) begin
          $display("port %0d waited too long for the stimulus to finish", p);
          errors = errors + 1;
          quit = 1'b1;
        end
      end else begin
        idle     = 0;
        wait_cnt = 0;
        do begin
          @(negedge clk);
          wait_cnt = wait_cnt + 1;
        end while (rsp[p].vld !== 1'b1 && wait_cnt < 10);
        e = exp_q[p].pop_front();
        if (rsp[p].vld !== 1'b1) begin
          $display("no response on port %0d for %s within 10 cycles", p, names[e.idx]);
          errors = errors + 1;
        end else begin
          if (cycle_cnt != e.cycle + nru_pkg::SRAM_DELAY) begin
            $display("[ERROR] %s latency: expected %0d, actual %0d", names[e.idx],
                     e.cycle + nru_pkg::SRAM_DELAY, cycle_cnt);
            errors = errors + 1;
          end
          if (rsp[p].dout !== e.data) begin
            $display("[ERROR] %s: expected %h, actual %h", names[e.idx], e.data, rsp[p].dout);
            errors = errors + 1;
          end
        end
      end
    end
  endtask

  initial begin
    req[0] = '0;
    req[1] = '0;
    for (int a = 0; a < nru_pkg::NUMADDR; a++) begin
      model[a] = '0;
    end
    for (int p = 0; p < nru_pkg::NUMRUPT; p++) begin
      commit_vld[p] = 1'b0;
    end
    build_table();
    waited = 0;
    while (rst !== 1'b0 && waited < 20) begin
      @(posedge clk);
      waited = waited + 1;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      $display("Errors found");
      $finish;
    end else begin
      // no read has been issued yet, so both ports stay quiet.
      repeat (3) begin
        @(negedge clk);
        if (rsp[0].vld !== 1'b0 || rsp[1].vld !== 1'b0) begin
          $display("a response appeared after reset before any read");
          errors = errors + 1;
        end
      end
      fork
        watch_port(0);
        watch_port(1);
        run_table();
      join
      $display("error count: %0d", errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

// ==== nru_tb_clk.sv ====
`timescale 1ns/100ps

module nru_tb_clk (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset is held for the first four rising edges.
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== nru_update_ctrl.sv ====
`timescale 1ns/100ps

module nru_update_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  nru_pkg::nru_req_t     req     [nru_pkg::NUMRUPT],
  input  nru_pkg::nru_partner_t partner [nru_pkg::NUMRUPT],
  output nru_pkg::nru_bank_wr_t bank_wr [nru_pkg::NUMRUPT]
);

  logic [nru_pkg::UPD_DELAY-1:0] hold_vld  [nru_pkg::NUMRUPT];
  logic [nru_pkg::BITADDR-1:0]   hold_addr [nru_pkg::NUMRUPT][nru_pkg::UPD_DELAY];
  logic [nru_pkg::WIDTH-1:0]     hold_word [nru_pkg::NUMRUPT][nru_pkg::UPD_DELAY];
  nru_pkg::nru_bank_wr_t         wr_hist   [nru_pkg::NUMRUPT][nru_pkg::UPD_LAT];

  genvar p;
  for (p = 0; p < nru_pkg::NUMRUPT; p++) begin : port_loop
    logic [nru_pkg::WIDTH-1:0] other_word;
    logic                      conflict;

    // port p owns logical bank p, so it keeps the word of the other bank.
    assign other_word = (p == 0) ? partner[p].word1 : partner[p].word0;

    always_ff @(posedge clk) begin
      if (rst) begin
        hold_vld[p] <= '0;
      end else begin
        hold_vld[p] <= {hold_vld[p][nru_pkg::UPD_DELAY-2:0], partner[p].vld};
      end
    end

    always_ff @(posedge clk) begin
      hold_addr[p][0] <= partner[p].addr;
      hold_word[p][0] <= other_word;
      for (int k = 1; k < nru_pkg::UPD_DELAY; k++) begin
        hold_addr[p][k] <= hold_addr[p][k-1];
        hold_word[p][k] <= hold_word[p][k-1];
      end
    end

    // storing din ^ other makes the XOR of both banks equal din.
    assign bank_wr[p].en   = req[p].write & hold_vld[p][nru_pkg::UPD_DELAY-1];
    assign bank_wr[p].addr = hold_addr[p][nru_pkg::UPD_DELAY-1];
    assign bank_wr[p].data = req[p].din ^ hold_word[p][nru_pkg::UPD_DELAY-1];

    // recent bank writes of this port, for the overlap check.
    always_ff @(posedge clk) begin
      if (rst) begin
        for (int k = 0; k < nru_pkg::UPD_LAT; k++) begin
          wr_hist[p][k].en <= 1'b0;
        end
      end else begin
        wr_hist[p][0] <= bank_wr[p];
        for (int k = 1; k < nru_pkg::UPD_LAT; k++) begin
          wr_hist[p][k] <= wr_hist[p][k-1];
        end
      end
    end

    // an update of the other port to this address within UPD_LAT cycles
    // would have read a stale partner word.
    always_comb begin
      conflict = bank_wr[1-p].en && (bank_wr[1-p].addr == bank_wr[p].addr);
      for (int k = 0; k < nru_pkg::UPD_LAT; k++) begin
        if (wr_hist[1-p][k].en && (wr_hist[1-p][k].addr == bank_wr[p].addr)) begin
          conflict = 1'b1;
        end
      end
    end

    assert_wr_slot: assert property (
      @(posedge clk) disable iff (rst) req[p].write |-> hold_vld[p][nru_pkg::UPD_DELAY-1]
    );

    assert_upd_overlap: assert property (
      @(posedge clk) disable iff (rst) bank_wr[p].en |-> !conflict
    );
  end

endmodule

// ==== verilog.f ====
nru_pkg.sv
nru_bank.sv
nru_read_lane.sv
nru_update_ctrl.sv
nru_sva_check.sv
nru_mem_top.sv
nru_tb_clk.sv
nru_tb.sv
